// ==== hdl/shim_bus_pkg.sv ====
/*
 * Bus types shared by the AFU shim blocks. It holds the AXI4-Lite channel
 * payloads on the host side and the request and response words that the
 * peers exchange with the memory arbiter. Compile it before any user.
 */

`default_nettype none

package shim_bus_pkg;

    // Data width of the host bus and of each memory word
    localparam int DATA_W = 32;

    // Host byte address width on the AXI4-Lite side
    localparam int ADDR_W = 16;

    // Word address width, sized for the largest bank
    localparam int MEM_AW = 8;

    // ==========================================================
    // AXI4-Lite channels, valid travels with the payload
    // ==========================================================

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } axil_w_t;

    // The response code is always OKAY in this design
    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } axil_b_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
    } axil_r_t;

    // ==========================================================
    // Memory side of the arbiter
    // ==========================================================

    // A peer holds this word stable until grant comes back
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [MEM_AW-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    // Grant is combinational, rvalid follows a read grant by one cycle
    typedef struct packed {
        logic              grant;
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/shim_ctrl_pkg.sv ====
/*
 * Control definitions of the AFU shim: the host register map, the fill
 * engine states and the command word that the MMIO slave hands to the
 * fill engine. Compile it after the bus package.
 */

`default_nettype none

package shim_ctrl_pkg;

    // Value returned by a read of REG_ID
    localparam logic [shim_bus_pkg::DATA_W-1:0] AFU_ID = 32'h5AF0_0001;

    // Any host address with this bit set falls into the memory window
    localparam int MEM_WIN_BIT = 12;

    // Byte offsets of the control registers
    typedef enum logic [shim_bus_pkg::ADDR_W-1:0] {
        REG_ID           = 16'h0000,
        REG_CTRL         = 16'h0008,
        REG_STATUS       = 16'h0010,
        REG_FILL_BASE    = 16'h0018,
        REG_FILL_LEN     = 16'h0020,
        REG_FILL_PATTERN = 16'h0028
    } reg_addr_e;

    // DONE is sticky and only a new start leaves it
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } fill_state_e;

    // Start is a one cycle pulse, the rest mirrors the host registers
    typedef struct packed {
        logic                              start;
        logic [shim_bus_pkg::MEM_AW-1:0]   base;
        logic [shim_bus_pkg::MEM_AW-1:0]   len;
        logic [shim_bus_pkg::DATA_W-1:0]   pattern;
    } fill_cmd_t;

endpackage

`default_nettype wire

// ==== hdl/local_mem_bank.sv ====
/*
 * Single port local memory bank. A valid write updates the addressed
 * word, a valid read presents the word on rdata one cycle later.
 */

`default_nettype none

module local_mem_bank
#(
    parameter int MEM_WORDS = 256
)
(
    input  logic                            ccip_to_afu,
    input  shim_bus_pkg::mem_req_t          req,
    output logic [shim_bus_pkg::DATA_W-1:0] rdata
);
    import shim_bus_pkg::*;

    logic [DATA_W-1:0] mem [MEM_WORDS];

    always_ff @(posedge ccip_to_afu)
    begin
        if (req.valid && req.write)
        begin
            mem[req.addr] <= req.wdata;
        end
        // Read data stays put until the next read
        if (req.valid && !req.write)
        begin
            rdata <= mem[req.addr];
        end
    end

    // Both peers wrap their word addresses to the bank depth
    a_addr_in_range: assert property (@(posedge ccip_to_afu)
        req.valid |-> int'(req.addr) < MEM_WORDS);

endmodule

`default_nettype wire

// ==== hdl/mem_arbiter.sv ====
/*
 * Two way round robin arbiter in front of the local memory bank. The
 * peer that did not win last goes first when both ask. Read data comes
 * back one cycle after the grant and is flagged only to the reader.
 */

`default_nettype none

module mem_arbiter
(
    input  logic                                ccip_to_afu,
    input  logic                                rst_n,
    input  shim_bus_pkg::mem_req_t              host_req,
    output shim_bus_pkg::mem_rsp_t              host_rsp,
    input  shim_bus_pkg::mem_req_t              fill_req,
    output shim_bus_pkg::mem_rsp_t              fill_rsp,
    output shim_bus_pkg::mem_req_t              bank_req,
    input  logic [shim_bus_pkg::DATA_W-1:0]     bank_rdata
);
    import shim_bus_pkg::*;

    logic host_gnt;
    logic fill_gnt;
    // Set when the fill engine took the most recent grant
    logic last_fill_q;
    // A read is in the bank this cycle, and who issued it
    logic rd_pend_q;
    logic owner_fill_q;

    assign host_gnt = host_req.valid && (!fill_req.valid || last_fill_q);
    assign fill_gnt = fill_req.valid && (!host_req.valid || !last_fill_q);

    always_comb
    begin
        if (fill_gnt)
        begin
            bank_req = fill_req;
        end
        else
        begin
            bank_req = host_req;
        end
        bank_req.valid = host_gnt || fill_gnt;

        host_rsp.grant  = host_gnt;
        host_rsp.rvalid = rd_pend_q && !owner_fill_q;
        host_rsp.rdata  = bank_rdata;
        fill_rsp.grant  = fill_gnt;
        fill_rsp.rvalid = rd_pend_q && owner_fill_q;
        fill_rsp.rdata  = bank_rdata;
    end

    always_ff @(posedge ccip_to_afu or negedge rst_n)
    begin
        if (!rst_n)
        begin
            last_fill_q  <= 1'b0;
            rd_pend_q    <= 1'b0;
            owner_fill_q <= 1'b0;
        end
        else
        begin
            rd_pend_q <= bank_req.valid && !bank_req.write;
            if (bank_req.valid)
            begin
                last_fill_q  <= fill_gnt;
                owner_fill_q <= fill_gnt;
            end
        end
    end

    a_one_grant: assert property (@(posedge ccip_to_afu) disable iff (!rst_n)
        !(host_rsp.grant && fill_rsp.grant));

endmodule

`default_nettype wire

// ==== hdl/fill_engine.sv ====
/*
 * Fill engine of the AFU shim. A start pulse latches base, length and
 * pattern, then one word per granted cycle is written with the pattern
 * plus its index. Busy is high while running and done stays set until
 * the next start.
 */

`default_nettype none

module fill_engine
#(
    parameter int MEM_WORDS = 256
)
(
    input  logic                     ccip_to_afu,
    input  logic                     rst_n,
    input  shim_ctrl_pkg::fill_cmd_t cmd,
    output logic                     busy,
    output logic                     done,
    output shim_bus_pkg::mem_req_t   mem_req,
    input  shim_bus_pkg::mem_rsp_t   mem_rsp
);
    import shim_bus_pkg::*;
    import shim_ctrl_pkg::*;

    fill_state_e       state_q;
    logic [MEM_AW-1:0] idx_q;
    logic [MEM_AW-1:0] base_q;
    logic [MEM_AW-1:0] len_q;
    logic [DATA_W-1:0] pattern_q;
    logic              last;

    // The word being offered is the final one of the range
    assign last = (idx_q == len_q - 1'b1);

    assign busy = (state_q == RUN);
    assign done = (state_q == DONE);

    // The request only moves on when the arbiter grants it
    always_comb
    begin
        mem_req.valid = (state_q == RUN);
        mem_req.write = 1'b1;
        mem_req.addr  = MEM_AW'((int'(base_q) + int'(idx_q)) % MEM_WORDS);
        mem_req.wdata = pattern_q + DATA_W'(idx_q);
    end

    always_ff @(posedge ccip_to_afu or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= IDLE;
            idx_q   <= '0;
        end
        else
        begin
            case (state_q)
                // A zero length start completes at once
                IDLE, DONE:
                begin
                    if (cmd.start)
                    begin
                        idx_q <= '0;
                        if (cmd.len == '0)
                        begin
                            state_q <= DONE;
                        end
                        else
                        begin
                            state_q <= RUN;
                        end
                    end
                end
                // Starts are ignored here
                RUN:
                begin
                    if (mem_rsp.grant && last)
                    begin
                        state_q <= DONE;
                    end
                    else if (mem_rsp.grant)
                    begin
                        idx_q <= idx_q + 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // The command is captured once so host writes during a run do not leak in
    always_ff @(posedge ccip_to_afu)
    begin
        if (cmd.start && state_q != RUN)
        begin
            base_q    <= cmd.base;
            len_q     <= cmd.len;
            pattern_q <= cmd.pattern;
        end
    end

    // Grants for the engine only ever answer writes issued in RUN
    a_grant_in_run: assert property (@(posedge ccip_to_afu) disable iff (!rst_n)
        mem_rsp.grant |-> state_q == RUN);
    // The arbiter never steers read data here, since the engine never reads
    a_no_rvalid: assert property (@(posedge ccip_to_afu) disable iff (!rst_n)
        !mem_rsp.rvalid);

endmodule

`default_nettype wire

// ==== hdl/mmio_slave.sv ====
/*
 * AXI4-Lite slave of the AFU shim. Register accesses are answered one
 * cycle after acceptance. Accesses with the window bit set become
 * requests to the memory arbiter and finish once granted, or for reads
 * once the read data has come back.
 */

`default_nettype none

module mmio_slave
#(
    parameter int MEM_WORDS = 256
)
(
    input  logic                     ccip_to_afu,
    input  logic                     rst_n,
    input  shim_bus_pkg::axil_aw_t   s_aw,
    output logic                     s_awready,
    input  shim_bus_pkg::axil_w_t    s_w,
    output logic                     s_wready,
    output shim_bus_pkg::axil_b_t    s_b,
    input  logic                     s_bready,
    input  shim_bus_pkg::axil_ar_t   s_ar,
    output logic                     s_arready,
    output shim_bus_pkg::axil_r_t    s_r,
    input  logic                     s_rready,
    output shim_ctrl_pkg::fill_cmd_t fill_cmd,
    input  logic                     fill_busy,
    input  logic                     fill_done,
    output shim_bus_pkg::mem_req_t   mem_req,
    input  shim_bus_pkg::mem_rsp_t   mem_rsp
);
    import shim_bus_pkg::*;
    import shim_ctrl_pkg::*;

    // Progress of a memory window access
    typedef enum logic [1:0] {
        SL_IDLE,
        SL_MEM_WR,
        SL_MEM_RD,
        SL_RD_WAIT
    } sl_state_e;

    sl_state_e         state_q;
    logic              idle;
    logic              wr_go;
    logic              rd_go;
    logic              bvalid_q;
    logic              rvalid_q;
    logic [DATA_W-1:0] rdata_q;
    logic              req_valid_q;
    logic              req_write_q;
    logic [MEM_AW-1:0] req_addr_q;
    logic [DATA_W-1:0] req_wdata_q;
    logic              start_q;
    logic [MEM_AW-1:0] base_q;
    logic [MEM_AW-1:0] len_q;
    logic [DATA_W-1:0] pattern_q;
    logic [DATA_W-1:0] reg_rdata;

    // Word index of a window byte address, wrapped to the bank depth
    function automatic logic [MEM_AW-1:0] word_of(input logic [ADDR_W-1:0] addr);
        return MEM_AW'(int'(addr[MEM_AW+1:2]) % MEM_WORDS);
    endfunction

    // ==========================================================
    // Handshake
    // ==========================================================

    // Nothing new is taken while a response waits for the host
    assign idle  = (state_q == SL_IDLE) && !bvalid_q && !rvalid_q;
    // A write needs AW and W together, and wins over a read
    assign wr_go = idle && s_aw.valid && s_w.valid;
    assign rd_go = idle && !wr_go && s_ar.valid;

    assign s_awready = wr_go;
    assign s_wready  = wr_go;
    assign s_arready = rd_go;

    always_comb
    begin
        s_b.valid     = bvalid_q;
        s_b.resp      = 2'b00;
        s_r.valid     = rvalid_q;
        s_r.data      = rdata_q;
        s_r.resp      = 2'b00;
        mem_req.valid = req_valid_q;
        mem_req.write = req_write_q;
        mem_req.addr  = req_addr_q;
        mem_req.wdata = req_wdata_q;
        fill_cmd.start   = start_q;
        fill_cmd.base    = base_q;
        fill_cmd.len     = len_q;
        fill_cmd.pattern = pattern_q;
    end

    // Register read mux, unmapped offsets read as zero
    always_comb
    begin
        case (reg_addr_e'(s_ar.addr))
            REG_ID:           reg_rdata = AFU_ID;
            REG_STATUS:       reg_rdata = DATA_W'({fill_done, fill_busy});
            REG_FILL_BASE:    reg_rdata = DATA_W'(base_q);
            REG_FILL_LEN:     reg_rdata = DATA_W'(len_q);
            REG_FILL_PATTERN: reg_rdata = pattern_q;
            default:          reg_rdata = '0;
        endcase
    end

    // ==========================================================
    // Control state and registers
    // ==========================================================

    always_ff @(posedge ccip_to_afu or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q     <= SL_IDLE;
            bvalid_q    <= 1'b0;
            rvalid_q    <= 1'b0;
            req_valid_q <= 1'b0;
            start_q     <= 1'b0;
            base_q      <= '0;
            len_q       <= '0;
            pattern_q   <= '0;
        end
        else
        begin
            start_q <= 1'b0;
            if (bvalid_q && s_bready)
            begin
                bvalid_q <= 1'b0;
            end
            if (rvalid_q && s_rready)
            begin
                rvalid_q <= 1'b0;
            end
            case (state_q)
                SL_IDLE:
                begin
                    if (wr_go && s_aw.addr[MEM_WIN_BIT])
                    begin
                        state_q     <= SL_MEM_WR;
                        req_valid_q <= 1'b1;
                    end
                    else if (wr_go)
                    begin
                        bvalid_q <= 1'b1;
                        case (reg_addr_e'(s_aw.addr))
                            REG_CTRL:         start_q   <= s_w.data[0];
                            REG_FILL_BASE:    base_q    <= s_w.data[MEM_AW-1:0];
                            REG_FILL_LEN:     len_q     <= s_w.data[MEM_AW-1:0];
                            REG_FILL_PATTERN: pattern_q <= s_w.data;
                            default:          ;
                        endcase
                    end
                    else if (rd_go && s_ar.addr[MEM_WIN_BIT])
                    begin
                        state_q     <= SL_MEM_RD;
                        req_valid_q <= 1'b1;
                    end
                    else if (rd_go)
                    begin
                        rvalid_q <= 1'b1;
                    end
                end
                // The write lands in the bank in the grant cycle
                SL_MEM_WR:
                begin
                    if (mem_rsp.grant)
                    begin
                        req_valid_q <= 1'b0;
                        bvalid_q    <= 1'b1;
                        state_q     <= SL_IDLE;
                    end
                end
                SL_MEM_RD:
                begin
                    if (mem_rsp.grant)
                    begin
                        req_valid_q <= 1'b0;
                        state_q     <= SL_RD_WAIT;
                    end
                end
                SL_RD_WAIT:
                begin
                    if (mem_rsp.rvalid)
                    begin
                        rvalid_q <= 1'b1;
                        state_q  <= SL_IDLE;
                    end
                end
                default: state_q <= SL_IDLE;
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge ccip_to_afu)
    begin
        if (wr_go)
        begin
            req_write_q <= 1'b1;
            req_addr_q  <= word_of(s_aw.addr);
            req_wdata_q <= s_w.data;
        end
        else if (rd_go)
        begin
            req_write_q <= 1'b0;
            req_addr_q  <= word_of(s_ar.addr);
        end
        if (rd_go && !s_ar.addr[MEM_WIN_BIT])
        begin
            rdata_q <= reg_rdata;
        end
        else if (state_q == SL_RD_WAIT && mem_rsp.rvalid)
        begin
            rdata_q <= mem_rsp.rdata;
        end
    end

    // Responses hold under back-pressure, and read data holds with them
    a_b_held: assert property (@(posedge ccip_to_afu) disable iff (!rst_n)
        s_b.valid && !s_bready |=> s_b.valid);
    a_r_held: assert property (@(posedge ccip_to_afu) disable iff (!rst_n)
        s_r.valid && !s_rready |=> s_r.valid && $stable(s_r.data));

    // No memory traffic from the host side while the host stalls a response
    a_no_req_stalled: assert property (@(posedge ccip_to_afu) disable iff (!rst_n)
        mem_req.valid |-> !s_b.valid && !s_r.valid);

endmodule

`default_nettype wire

// ==== hdl/afu_platform_shim.sv ====
/*
 * Top level of the AFU shim. It joins the host AXI4-Lite slave and the
 * fill engine to one local memory bank through the arbiter. MEM_WORDS
 * sets the bank depth for every block that addresses it.
 */

`default_nettype none

module afu_platform_shim
#(
    parameter int MEM_WORDS = 256
)
(
    input  logic                   ccip_to_afu,
    input  logic                   rst_n,
    input  shim_bus_pkg::axil_aw_t s_aw,
    output logic                   s_awready,
    input  shim_bus_pkg::axil_w_t  s_w,
    output logic                   s_wready,
    output shim_bus_pkg::axil_b_t  s_b,
    input  logic                   s_bready,
    input  shim_bus_pkg::axil_ar_t s_ar,
    output logic                   s_arready,
    output shim_bus_pkg::axil_r_t  s_r,
    input  logic                   s_rready
);
    import shim_bus_pkg::*;
    import shim_ctrl_pkg::*;

    fill_cmd_t         fill_cmd;
    logic              fill_busy;
    logic              fill_done;
    mem_req_t          host_req;
    mem_rsp_t          host_rsp;
    mem_req_t          fill_req;
    mem_rsp_t          fill_rsp;
    mem_req_t          bank_req;
    logic [DATA_W-1:0] bank_rdata;

    // ==========================================================
    // Host side
    // ==========================================================

    mmio_slave #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mmio_slave (
        .ccip_to_afu (ccip_to_afu),
        .rst_n       (rst_n),
        .s_aw        (s_aw),
        .s_awready   (s_awready),
        .s_w         (s_w),
        .s_wready    (s_wready),
        .s_b         (s_b),
        .s_bready    (s_bready),
        .s_ar        (s_ar),
        .s_arready   (s_arready),
        .s_r         (s_r),
        .s_rready    (s_rready),
        .fill_cmd    (fill_cmd),
        .fill_busy   (fill_busy),
        .fill_done   (fill_done),
        .mem_req     (host_req),
        .mem_rsp     (host_rsp)
    );

    fill_engine #(
        .MEM_WORDS (MEM_WORDS)
    ) u_fill_engine (
        .ccip_to_afu (ccip_to_afu),
        .rst_n       (rst_n),
        .cmd         (fill_cmd),
        .busy        (fill_busy),
        .done        (fill_done),
        .mem_req     (fill_req),
        .mem_rsp     (fill_rsp)
    );

    // ==========================================================
    // Memory side
    // ==========================================================

    mem_arbiter u_mem_arbiter (
        .ccip_to_afu (ccip_to_afu),
        .rst_n       (rst_n),
        .host_req    (host_req),
        .host_rsp    (host_rsp),
        .fill_req    (fill_req),
        .fill_rsp    (fill_rsp),
        .bank_req    (bank_req),
        .bank_rdata  (bank_rdata)
    );

    local_mem_bank #(
        .MEM_WORDS (MEM_WORDS)
    ) u_local_mem_bank (
        .ccip_to_afu (ccip_to_afu),
        .req         (bank_req),
        .rdata       (bank_rdata)
    );

endmodule

`default_nettype wire

// ==== dv/tb_afu_platform_shim.sv ====
/*
 * Testbench of the AFU shim. It reads operations from the input file,
 * drives them as AXI4-Lite transactions with random response delays,
 * and checks every read against the expected value of its line.
 */

`default_nettype none

module tb_afu_platform_shim;
    timeunit 1ns;
    timeprecision 1ps;

    import shim_bus_pkg::*;

    localparam int MEM_WORDS     = 256;
    localparam int CLK_PERIOD    = 40;
    // Outputs are read in the middle of the low phase, well clear of both edges
    localparam int SAMPLE_DELAY  = CLK_PERIOD / 4;
    localparam int CYCLES_PER_OP = 200;

    logic     ccip_to_afu = 1'b0;
    logic     rst_n;
    axil_aw_t s_aw;
    logic     s_awready;
    axil_w_t  s_w;
    logic     s_wready;
    axil_b_t  s_b;
    logic     s_bready;
    axil_ar_t s_ar;
    logic     s_arready;
    axil_r_t  s_r;
    logic     s_rready;

    // One entry per operation line of the input file
    string             op_q[$];
    logic [ADDR_W-1:0] addr_q[$];
    logic [DATA_W-1:0] data_q[$];
    logic [DATA_W-1:0] exp_q[$];
    bit                loaded = 1'b0;

    always #(CLK_PERIOD / 2) ccip_to_afu = ~ccip_to_afu;

    afu_platform_shim #(
        .MEM_WORDS (MEM_WORDS)
    ) DUT (
        .ccip_to_afu (ccip_to_afu),
        .rst_n       (rst_n),
        .s_aw        (s_aw),
        .s_awready   (s_awready),
        .s_w         (s_w),
        .s_wready    (s_wready),
        .s_b         (s_b),
        .s_bready    (s_bready),
        .s_ar        (s_ar),
        .s_arready   (s_arready),
        .s_r         (s_r),
        .s_rready    (s_rready)
    );

    // ============================================================
    // Failure handling and checks
    // ============================================================

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            abort_run($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // Next falling edge plus a quarter period
    task automatic next_sample_point();
        @(negedge ccip_to_afu);
        #(SAMPLE_DELAY);
    endtask

    // ============================================================
    // AXI4-Lite host transactions
    // ============================================================

    task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        int unsigned stall;
        stall = $urandom % 4;
        @(negedge ccip_to_afu);
        s_aw.valid = 1'b1;
        s_aw.addr  = addr;
        s_w.valid  = 1'b1;
        s_w.data   = data;
        #(SAMPLE_DELAY);
        while (!(s_awready && s_wready))
        begin
            next_sample_point();
        end
        // AW and W are taken at the rising edge in between
        @(negedge ccip_to_afu);
        s_aw.valid = 1'b0;
        s_w.valid  = 1'b0;
        // Hold the response back for a random number of cycles
        repeat (stall) @(negedge ccip_to_afu);
        s_bready = 1'b1;
        #(SAMPLE_DELAY);
        while (!s_b.valid)
        begin
            next_sample_point();
        end
        check_value("s_b.resp", 32'(s_b.resp), 32'h0);
        @(negedge ccip_to_afu);
        s_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        int unsigned stall;
        stall = $urandom % 4;
        @(negedge ccip_to_afu);
        s_ar.valid = 1'b1;
        s_ar.addr  = addr;
        #(SAMPLE_DELAY);
        while (!s_arready)
        begin
            next_sample_point();
        end
        @(negedge ccip_to_afu);
        s_ar.valid = 1'b0;
        repeat (stall) @(negedge ccip_to_afu);
        s_rready = 1'b1;
        #(SAMPLE_DELAY);
        while (!s_r.valid)
        begin
            next_sample_point();
        end
        // Data is stable here and the handshake completes on the coming edge
        data = s_r.data;
        check_value("s_r.resp", 32'(s_r.resp), 32'h0);
        @(negedge ccip_to_afu);
        s_rready = 1'b0;
    endtask

    // ============================================================
    // Input file
    // ============================================================

    // Lines starting with # are column notes and blank lines are skipped
    task automatic load_input();
        int                fd;
        int                n;
        string             line;
        string             op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] exp;
        fd = $fopen("dv/shim_input.txt", "r");
        if (fd == 0)
        begin
            abort_run("could not open the input file dv/shim_input.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#")
                begin
                    n = $sscanf(line, "%s %h %h %h", op, addr, data, exp);
                    if (n == 4)
                    begin
                        op_q.push_back(op);
                        addr_q.push_back(addr);
                        data_q.push_back(data);
                        exp_q.push_back(exp);
                    end
                end
            end
            $fclose(fd);
            if (op_q.size() == 0)
            begin
                abort_run("the input file holds no operations");
            end
            else
            begin
                loaded = 1'b1;
            end
        end
    endtask

    // Each operation line buys the run a fixed number of cycles
    initial
    begin : watchdog
        wait (loaded);
        repeat (CYCLES_PER_OP * op_q.size()) @(posedge ccip_to_afu);
        abort_run($sformatf("timeout, the run did not end within %0d clock cycles",
                            CYCLES_PER_OP * op_q.size()));
    end

    // ============================================================
    // Main sequence
    // ============================================================

    initial
    begin
        logic [DATA_W-1:0] got;
        s_aw     = '0;
        s_w      = '0;
        s_ar     = '0;
        s_bready = 1'b0;
        s_rready = 1'b0;
        rst_n    = 1'b0;
        void'($urandom(41385));
        load_input();

        // Reset is held over two full clock cycles
        repeat (2) @(negedge ccip_to_afu);
        rst_n = 1'b1;
        #(SAMPLE_DELAY);
        check_value("s_b.valid", 32'(s_b.valid), 32'h0);
        check_value("s_r.valid", 32'(s_r.valid), 32'h0);
        check_value("s_awready", 32'(s_awready), 32'h0);
        check_value("s_arready", 32'(s_arready), 32'h0);

        for (int i = 0; i < op_q.size(); i++)
        begin
            if (op_q[i] == "WR")
            begin
                axil_write(addr_q[i], data_q[i]);
            end
            else if (op_q[i] == "RD")
            begin
                axil_read(addr_q[i], got);
                check_value($sformatf("s_r.data at 0x%04h", addr_q[i]), got, exp_q[i]);
            end
            else if (op_q[i] == "POLL")
            begin
                // Only the watchdog limits how long this may take
                axil_read(addr_q[i], got);
                while (got !== exp_q[i])
                begin
                    axil_read(addr_q[i], got);
                end
            end
            else
            begin
                abort_run($sformatf("unknown operation %s on input line %0d", op_q[i], i));
            end
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/shim_bus_pkg.sv
hdl/shim_ctrl_pkg.sv
hdl/local_mem_bank.sv
hdl/mem_arbiter.sv
hdl/fill_engine.sv
hdl/mmio_slave.sv
hdl/afu_platform_shim.sv
dv/tb_afu_platform_shim.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the AFU shim testbench with Verilator and runs it from the project root.
# The run counts as failed when the log holds the testbench fail line.

set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f flist.f \
    --top-module tb_afu_platform_shim \
    -o sim_tb

# The simulator status is not trusted here, the log decides
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Testbench failed" sim.log
then
    echo "run_sim: simulation reported a failure"
    exit 1
fi

echo "run_sim: simulation finished without a reported failure"
exit 0

// ==== dv/shim_input.txt ====
# op    byte_addr  wdata     expected  (all values in hex)
# WR writes wdata, RD checks the read value, POLL rereads until expected appears
RD   0000 00000000 5AF00001
WR   0018 000000FC 00000000
RD   0018 00000000 000000FC
WR   0020 00000006 00000000
RD   0020 00000000 00000006
WR   0028 A5A50000 00000000
RD   0028 00000000 A5A50000
WR   13FC DEADBEEF 00000000
RD   13FC 00000000 DEADBEEF
WR   1100 12345678 00000000
WR   1008 CAFE0002 00000000
RD   0010 00000000 00000000
WR   0008 00000001 00000000
WR   1200 0BADF00D 00000000
RD   1100 00000000 12345678
RD   1200 00000000 0BADF00D
POLL 0010 00000000 00000002
RD   13F0 00000000 A5A50000
RD   13F4 00000000 A5A50001
RD   13F8 00000000 A5A50002
RD   13FC 00000000 A5A50003
RD   1000 00000000 A5A50004
RD   1004 00000000 A5A50005
RD   1008 00000000 CAFE0002
RD   1100 00000000 12345678
